/* common/pnr_pkg.sv */
package pnr_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Sizes
  ///////////////////////////////////////////////////////////////////////

  localparam int unsigned SAMPLE_W   = 14;  // ADC/DAC sample width
  localparam int unsigned RAW_W      = 16;  // raw ADC word, 2 reserved LSBs
  localparam int unsigned NUM_THRESH = 6;   // photon thresholds

  ///////////////////////////////////////////////////////////////////////
  // Types
  ///////////////////////////////////////////////////////////////////////

  // Two's complement sample
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Raw ADC word as it comes off the pins
  typedef logic [RAW_W-1:0] raw_t;

  // Negative-slope offset code for the DAC pins
  typedef logic [SAMPLE_W-1:0] dac_code_t;

  // Sum of two samples, one guard bit for overflow
  typedef logic signed [SAMPLE_W:0] sum_t;

  // One threshold per photon number, element 0 for one photon
  typedef sample_t [NUM_THRESH-1:0] thresh_arr_t;

  // Photon count 0..6
  typedef logic [2:0] photon_num_t;

  // Pulse tracker states
  typedef enum logic
  {
    PULSE_IDLE = 1'b0,  // level at zero
    PULSE_HIGH = 1'b1   // inside a pulse
  } pulse_state_e;

  ///////////////////////////////////////////////////////////////////////
  // Negative-slope conversion
  ///////////////////////////////////////////////////////////////////////

  // MSB kept, the rest inverted
  // Same rule both ways, ADC code in and DAC code out
  function automatic logic [SAMPLE_W-1:0] neg_slope(input logic [SAMPLE_W-1:0] val);
    return {val[SAMPLE_W-1], ~val[SAMPLE_W-2:0]};
  endfunction

endpackage

/* hdl/adc_frontend.sv */
module adc_frontend
  import pnr_pkg::*;
#(
  parameter int unsigned SAMPLE_W = pnr_pkg::SAMPLE_W  // converted sample width
)(
  input  logic    adc_clk,         // ADC clock
  input  logic    rst_n_i,         // async reset, active low
  // raw ADC pins
  input  raw_t    adc_a_raw_i,     // CH A raw word
  input  raw_t    adc_b_raw_i,     // CH B raw word
  // loopback from the DAC path
  input  sample_t loop_a_i,        // CH A DAC sample
  input  sample_t loop_b_i,        // CH B DAC sample
  input  logic    digital_loop_i,  // 1 = DAC samples replace ADC
  // converted samples
  output sample_t adc_a_o,         // CH A two's complement
  output sample_t adc_b_o          // CH B two's complement
);

///////////////////////////////////////////////////////////////////////
// Input registers
///////////////////////////////////////////////////////////////////////

logic [SAMPLE_W-1:0] raw_a_q;  // CH A, reserved bits gone
logic [SAMPLE_W-1:0] raw_b_q;  // CH B, reserved bits gone

// Two LSBs of the 16 bit word are reserved, keep the top field only
always_ff @(posedge adc_clk or negedge rst_n_i)
begin
  if (!rst_n_i)
  begin
    raw_a_q <= '0;
    raw_b_q <= '0;
  end
  else
  begin
    raw_a_q <= adc_a_raw_i[RAW_W-1 -: SAMPLE_W];  // bits 15..2
    raw_b_q <= adc_b_raw_i[RAW_W-1 -: SAMPLE_W];
  end
end

///////////////////////////////////////////////////////////////////////
// Conversion and loopback mux
///////////////////////////////////////////////////////////////////////

sample_t conv_a;  // converted CH A
sample_t conv_b;  // converted CH B

// Negative slope into two's complement
assign conv_a = sample_t'(neg_slope(raw_a_q));
assign conv_b = sample_t'(neg_slope(raw_b_q));

// Loop samples are already registered on the DAC side,
// so both branches carry the same one edge of delay
assign adc_a_o = digital_loop_i ? loop_a_i : conv_a;
assign adc_b_o = digital_loop_i ? loop_b_i : conv_b;

endmodule

/* hdl/dac_backend.sv */
module dac_backend
  import pnr_pkg::*;
(
  input  logic      adc_clk,   // single clock, DAC runs here too
  input  logic      rst_n_i,   // async reset, active low
  // waveform and correction samples
  input  sample_t   wave_a_i,  // CH A waveform
  input  sample_t   wave_b_i,  // CH B waveform
  input  sample_t   corr_a_i,  // CH A correction
  input  sample_t   corr_b_i,  // CH B correction
  // registered samples back to the ADC side
  output sample_t   loop_a_o,  // CH A loop sample
  output sample_t   loop_b_o,  // CH B loop sample
  // DAC pin codes
  output dac_code_t dac_a_o,   // CH A neg-slope code
  output dac_code_t dac_b_o    // CH B neg-slope code
);

///////////////////////////////////////////////////////////////////////
// Sum and saturation
///////////////////////////////////////////////////////////////////////

// Clamp a 15 bit sum into the 14 bit range
// Top two bits disagree -> overflow, pick full scale of the sum's sign
function automatic sample_t sat(input sum_t sum);
  if (sum[SAMPLE_W] ^ sum[SAMPLE_W-1])
    return {sum[SAMPLE_W], {(SAMPLE_W-1){~sum[SAMPLE_W]}}};
  else
    return sum[SAMPLE_W-1:0];
endfunction

sum_t    sum_a;  // CH A raw sum
sum_t    sum_b;  // CH B raw sum
sample_t sat_a;  // CH A clamped
sample_t sat_b;  // CH B clamped

// Sign extend before adding, no wrap in the guard bit
assign sum_a = sum_t'(wave_a_i) + sum_t'(corr_a_i);
assign sum_b = sum_t'(wave_b_i) + sum_t'(corr_b_i);

assign sat_a = sat(sum_a);
assign sat_b = sat(sum_b);

///////////////////////////////////////////////////////////////////////
// Output register
///////////////////////////////////////////////////////////////////////

sample_t dac_a_q;  // CH A registered sample
sample_t dac_b_q;  // CH B registered sample

always_ff @(posedge adc_clk or negedge rst_n_i)
begin
  if (!rst_n_i)
  begin
    dac_a_q <= '0;  // code 0x1FFF on the pins
    dac_b_q <= '0;
  end
  else
  begin
    dac_a_q <= sat_a;
    dac_b_q <= sat_b;
  end
end

// Same register feeds loopback and the pins
assign loop_a_o = dac_a_q;
assign loop_b_o = dac_b_q;

// Two's complement back to negative-slope offset code
assign dac_a_o = dac_code_t'(neg_slope(dac_a_q));
assign dac_b_o = dac_code_t'(neg_slope(dac_b_q));

endmodule

/* pnr/pnr_level.sv */
module pnr_level
  import pnr_pkg::*;
(
  input  logic        adc_clk,   // ADC clock
  input  logic        rst_n_i,   // async reset, active low
  input  sample_t     sample_i,  // CH A sample
  input  thresh_arr_t thresh_i,  // photon thresholds, any order
  output photon_num_t level_o    // registered photon level
);

///////////////////////////////////////////////////////////////////////
// Comparator bank
///////////////////////////////////////////////////////////////////////

logic [NUM_THRESH-1:0] hit;  // sample above threshold i

// Signed compare, strictly greater
always_comb
begin
  for (int i = 0; i < NUM_THRESH; i++)
  begin
    hit[i] = (sample_i > thresh_i[i]);
  end
end

///////////////////////////////////////////////////////////////////////
// Hit count
///////////////////////////////////////////////////////////////////////

photon_num_t level_d;  // number of thresholds passed

// Population count, not a priority encode
// Unsorted thresholds still give a sane level
always_comb
begin
  level_d = '0;
  for (int i = 0; i < NUM_THRESH; i++)
  begin
    level_d = level_d + photon_num_t'(hit[i]);
  end
end

// Level register, one edge of latency
always_ff @(posedge adc_clk or negedge rst_n_i)
begin
  if (!rst_n_i)
  begin
    level_o <= '0;
  end
  else
  begin
    level_o <= level_d;
  end
end

endmodule

/* pnr/pnr_pulse_fsm.sv */
module pnr_pulse_fsm
  import pnr_pkg::*;
(
  input  logic        adc_clk,       // ADC clock
  input  logic        rst_n_i,       // async reset, active low
  input  photon_num_t level_i,       // photon level per sample
  output photon_num_t photon_num_o,  // peak of the last pulse
  output logic        photon_vld_o   // one cycle event strobe
);

///////////////////////////////////////////////////////////////////////
// State and peak tracking
///////////////////////////////////////////////////////////////////////

pulse_state_e state_q, state_d;  // pulse tracker state
photon_num_t  peak_q,  peak_d;   // running peak of current pulse
photon_num_t  num_q,   num_d;    // reported photon number
logic         vld_q,   vld_d;    // event strobe

always_comb
begin
  state_d = state_q;
  peak_d  = peak_q;
  num_d   = num_q;  // held between events
  vld_d   = 1'b0;   // strobe by default low
  case (state_q)
    PULSE_IDLE:
    begin
      // First nonzero level opens a pulse
      if (level_i != '0)
      begin
        state_d = PULSE_HIGH;
        peak_d  = level_i;
      end
    end
    PULSE_HIGH:
    begin
      if (level_i == '0)
      begin
        // Pulse over, report its peak
        state_d = PULSE_IDLE;
        num_d   = peak_q;
        vld_d   = 1'b1;
        peak_d  = '0;
      end
      else if (level_i > peak_q)
      begin
        peak_d = level_i;  // new maximum
      end
    end
    default:
    begin
      state_d = PULSE_IDLE;
      peak_d  = '0;
    end
  endcase
end

always_ff @(posedge adc_clk or negedge rst_n_i)
begin
  if (!rst_n_i)
  begin
    state_q <= PULSE_IDLE;
    peak_q  <= '0;
    num_q   <= '0;
    vld_q   <= 1'b0;
  end
  else
  begin
    state_q <= state_d;
    peak_q  <= peak_d;
    num_q   <= num_d;
    vld_q   <= vld_d;
  end
end

assign photon_num_o = num_q;
assign photon_vld_o = vld_q;

endmodule

/* pnr/pnr_histogram.sv */
module pnr_histogram
  import pnr_pkg::*;
#(
  parameter int unsigned HIST_W = 16  // counter width, 2 or more
)(
  input  logic              adc_clk,       // ADC clock
  input  logic              rst_n_i,       // async reset, active low
  input  logic              event_i,       // photon event strobe
  input  photon_num_t       photon_num_i,  // photon number of the event
  input  logic              hist_clr_i,    // clear all counters
  input  photon_num_t       hist_sel_i,    // counter select for read
  output logic [HIST_W-1:0] hist_cnt_o     // selected count
);

///////////////////////////////////////////////////////////////////////
// Event counters
///////////////////////////////////////////////////////////////////////

logic [HIST_W-1:0] cnt_q [1:NUM_THRESH];  // one per photon number

for (genvar i = 1; i <= NUM_THRESH; i++)
begin : g_cnt
  logic inc;  // event of this photon number

  assign inc = event_i && (photon_num_i == photon_num_t'(i));

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_q[i] <= '0;
    end
    else if (hist_clr_i)
    begin
      cnt_q[i] <= '0;  // clear beats increment
    end
    else if (inc && (cnt_q[i] != '1))
    begin
      cnt_q[i] <= cnt_q[i] + 1'b1;  // stop at all ones
    end
  end
end

///////////////////////////////////////////////////////////////////////
// Read mux
///////////////////////////////////////////////////////////////////////

// Combinational read, selects 0 and 7 return zero
always_comb
begin
  hist_cnt_o = '0;
  for (int i = 1; i <= NUM_THRESH; i++)
  begin
    if (hist_sel_i == photon_num_t'(i))
    begin
      hist_cnt_o = cnt_q[i];
    end
  end
end

endmodule

/* hdl/pnr_top.sv */
module pnr_top
  import pnr_pkg::*;
#(
  parameter int unsigned HIST_W = 16  // histogram counter width
)(
  input  logic              adc_clk,         // ADC clock
  input  logic              rst_n_i,         // async reset, active low
  // ADC
  input  raw_t              adc_a_raw_i,     // CH A raw word
  input  raw_t              adc_b_raw_i,     // CH B raw word
  input  logic              digital_loop_i,  // DAC -> ADC loopback
  // DAC sources
  input  sample_t           wave_a_i,        // CH A waveform
  input  sample_t           wave_b_i,        // CH B waveform
  input  sample_t           corr_a_i,        // CH A correction
  input  sample_t           corr_b_i,        // CH B correction
  // PNR control
  input  thresh_arr_t       thresh_i,        // photon thresholds
  input  logic              hist_clr_i,      // histogram clear
  input  photon_num_t       hist_sel_i,      // histogram select
  // monitor samples
  output sample_t           adc_a_o,         // CH A sample
  output sample_t           adc_b_o,         // CH B sample
  // DAC pins
  output dac_code_t         dac_a_o,         // CH A code
  output dac_code_t         dac_b_o,         // CH B code
  // PNR results
  output photon_num_t       photon_num_o,    // photon number
  output logic              photon_vld_o,    // event strobe
  output logic [HIST_W-1:0] hist_cnt_o       // selected count
);

sample_t     loop_a;  // DAC sample looped to ADC side
sample_t     loop_b;
photon_num_t level;   // per-sample photon level

///////////////////////////////////////////////////////////////////////
// Analog front end
///////////////////////////////////////////////////////////////////////

adc_frontend #(
  .SAMPLE_W (SAMPLE_W)
) i_adc_frontend (
  .adc_clk        (adc_clk       ),
  .rst_n_i        (rst_n_i       ),
  .adc_a_raw_i    (adc_a_raw_i   ),
  .adc_b_raw_i    (adc_b_raw_i   ),
  .loop_a_i       (loop_a        ),
  .loop_b_i       (loop_b        ),
  .digital_loop_i (digital_loop_i),
  .adc_a_o        (adc_a_o       ),  // also feeds PNR
  .adc_b_o        (adc_b_o       )
);

dac_backend i_dac_backend (
  .adc_clk  (adc_clk ),
  .rst_n_i  (rst_n_i ),
  .wave_a_i (wave_a_i),
  .wave_b_i (wave_b_i),
  .corr_a_i (corr_a_i),
  .corr_b_i (corr_b_i),
  .loop_a_o (loop_a  ),
  .loop_b_o (loop_b  ),
  .dac_a_o  (dac_a_o ),
  .dac_b_o  (dac_b_o )
);

///////////////////////////////////////////////////////////////////////
// Photon number discriminator, CH A only
///////////////////////////////////////////////////////////////////////

pnr_level i_pnr_level (
  .adc_clk  (adc_clk ),
  .rst_n_i  (rst_n_i ),
  .sample_i (adc_a_o ),
  .thresh_i (thresh_i),
  .level_o  (level   )
);

pnr_pulse_fsm i_pnr_pulse_fsm (
  .adc_clk      (adc_clk     ),
  .rst_n_i      (rst_n_i     ),
  .level_i      (level       ),
  .photon_num_o (photon_num_o),
  .photon_vld_o (photon_vld_o)
);

pnr_histogram #(
  .HIST_W (HIST_W)
) i_pnr_histogram (
  .adc_clk      (adc_clk     ),
  .rst_n_i      (rst_n_i     ),
  .event_i      (photon_vld_o),
  .photon_num_i (photon_num_o),
  .hist_clr_i   (hist_clr_i  ),
  .hist_sel_i   (hist_sel_i  ),
  .hist_cnt_o   (hist_cnt_o  )
);

endmodule

/* bench/pnr_top_assertions.sv */
module pnr_top_assertions
  import pnr_pkg::*;
(
  input logic        adc_clk,       // ADC clock
  input logic        rst_n_i,       // async reset, active low
  input logic        photon_vld_i,  // event strobe from the DUT
  input photon_num_t photon_num_i   // photon number from the DUT
);

timeunit 1ns;
timeprecision 1ps;

///////////////////////////////////////////////////////////////////////
// Event strobe rules
///////////////////////////////////////////////////////////////////////

// Strobe lasts exactly one cycle
vld_single: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  photon_vld_i |=> !photon_vld_i)
  else $error("photon_vld_o high for two cycles in a row");

// An event always carries one to six photons
num_range: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  photon_vld_i |-> (photon_num_i >= 3'd1 && photon_num_i <= 3'd6))
  else $error("photon_num_o out of range during an event");

// Quiet while in reset
vld_in_reset: assert property (@(posedge adc_clk)
  !rst_n_i |-> !photon_vld_i)
  else $error("photon_vld_o high during reset");

endmodule

bind pnr_top pnr_top_assertions i_pnr_top_assertions (
  .adc_clk      (adc_clk     ),
  .rst_n_i      (rst_n_i     ),
  .photon_vld_i (photon_vld_o),
  .photon_num_i (photon_num_o)
);

/* bench/pnr_top_tb.sv */
module pnr_top_tb
  import pnr_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int unsigned HIST_W   = 16;   // histogram counter width
localparam int unsigned RST_CYC  = 8;    // reset length in cycles
localparam int unsigned EVT_TMO  = 20;   // cycles to wait for an event
localparam int unsigned N_STREAM = 300;  // samples per stream test
localparam int unsigned N_PULSE  = 64;   // pulses in the event test
localparam sample_t     MAX_S    = sample_t'(8191);   // nothing exceeds it
localparam sample_t     BASE     = sample_t'(-8192);  // below every threshold

logic              adc_clk = 1'b0;
logic              rst_n_i;
raw_t              adc_a_raw_i;
raw_t              adc_b_raw_i;
logic              digital_loop_i;
sample_t           wave_a_i;
sample_t           wave_b_i;
sample_t           corr_a_i;
sample_t           corr_b_i;
thresh_arr_t       thresh_i;
logic              hist_clr_i;
photon_num_t       hist_sel_i;
sample_t           adc_a_o;
sample_t           adc_b_o;
dac_code_t         dac_a_o;
dac_code_t         dac_b_o;
photon_num_t       photon_num_o;
logic              photon_vld_o;
logic [HIST_W-1:0] hist_cnt_o;

int          seed = 63304;           // fixed seed for $random
int          tally [0:7] = '{default: 0};  // model histogram
thresh_arr_t thr;                     // model copy of the thresholds

always #2 adc_clk = ~adc_clk;  // 4 ns period

pnr_top #(
  .HIST_W (HIST_W)
) i_pnr_top (
  .adc_clk        (adc_clk       ),
  .rst_n_i        (rst_n_i       ),
  .adc_a_raw_i    (adc_a_raw_i   ),
  .adc_b_raw_i    (adc_b_raw_i   ),
  .digital_loop_i (digital_loop_i),
  .wave_a_i       (wave_a_i      ),
  .wave_b_i       (wave_b_i      ),
  .corr_a_i       (corr_a_i      ),
  .corr_b_i       (corr_b_i      ),
  .thresh_i       (thresh_i      ),
  .hist_clr_i     (hist_clr_i    ),
  .hist_sel_i     (hist_sel_i    ),
  .adc_a_o        (adc_a_o       ),
  .adc_b_o        (adc_b_o       ),
  .dac_a_o        (dac_a_o       ),
  .dac_b_o        (dac_b_o       ),
  .photon_num_o   (photon_num_o  ),
  .photon_vld_o   (photon_vld_o  ),
  .hist_cnt_o     (hist_cnt_o    )
);

///////////////////////////////////////////////////////////////////////
// Reference model
///////////////////////////////////////////////////////////////////////

// Top bit of raw 15..2 kept and the rest inverted
function automatic sample_t conv_raw(raw_t raw);
  sample_t s;
  s[13]   = raw[15];
  s[12:0] = ~raw[14:2];
  return s;
endfunction

// Sample back to a raw word with filler in the reserved LSBs
function automatic raw_t make_raw(sample_t s, logic [1:0] junk);
  return {s[13], ~s[12:0], junk};
endfunction

function automatic sample_t sat_sum(sample_t w, sample_t c);
  int s;
  s = int'(w) + int'(c);
  if (s > 8191)
    s = 8191;  // positive full scale
  else if (s < -8192)
    s = -8192;
  return sample_t'(s);
endfunction

function automatic dac_code_t enc_dac(sample_t s);
  return {s[13], ~s[12:0]};
endfunction

// Count of thresholds strictly exceeded in a signed compare
function automatic photon_num_t level_of(sample_t s, thresh_arr_t t);
  photon_num_t n;
  n = '0;
  for (int i = 0; i < NUM_THRESH; i++)
    if (s > t[i])
      n = n + 1'b1;
  return n;
endfunction

function automatic sample_t thr_min(thresh_arr_t t);
  sample_t m;
  m = t[0];
  for (int i = 1; i < NUM_THRESH; i++)
    if (t[i] < m)
      m = t[i];
  return m;
endfunction

function automatic int rand_range(int lo, int hi);
  return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
endfunction

// Random sample strictly above lo gives at least one photon
function automatic sample_t rand_above(sample_t lo);
  return sample_t'(rand_range(int'(lo) + 1, 8191));
endfunction

///////////////////////////////////////////////////////////////////////
// Compare tasks
///////////////////////////////////////////////////////////////////////

task automatic fail_stop();
  $display("FAIL: see errors above");
  $fatal(1, "simulation stopped");
endtask

task automatic check_sample(string name, sample_t exp, sample_t act);
  if (exp !== act)
  begin
    $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    fail_stop();
  end
endtask

task automatic check_dac(string name, dac_code_t exp, dac_code_t act);
  if (exp !== act)
  begin
    $display("Mismatch %s: expected 0x%h, actual 0x%h", name, exp, act);
    fail_stop();
  end
endtask

task automatic check_photon(string name, photon_num_t exp, photon_num_t act);
  if (exp !== act)
  begin
    $display("Mismatch %s photon number: expected %0d, actual %0d", name, exp, act);
    fail_stop();
  end
endtask

task automatic check_count(string name, logic [HIST_W-1:0] exp, logic [HIST_W-1:0] act);
  if (exp !== act)
  begin
    $display("Mismatch %s count: expected %0d, actual %0d", name, exp, act);
    fail_stop();
  end
endtask

task automatic check_flag(string name, logic exp, logic act);
  if (exp !== act)
  begin
    $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    fail_stop();
  end
endtask

task automatic check_latency(string name, int exp, int act);
  if (exp != act)
  begin
    $display("Mismatch %s latency: expected %0d edges, actual %0d", name, exp, act);
    fail_stop();
  end
endtask

///////////////////////////////////////////////////////////////////////
// Stimulus
///////////////////////////////////////////////////////////////////////

// Random pair or two large values of one sign to force clamping
task automatic rand_pair(output sample_t w, output sample_t c, input logic big);
  logic neg;
  w = sample_t'($random(seed));
  c = sample_t'($random(seed));
  if (big)
  begin
    neg = $random(seed);
    w   = sample_t'(rand_range(4096, 8191));
    c   = sample_t'(rand_range(4096, 8191));
    if (neg)
    begin
      w = -w;
      c = -c;
    end
  end
endtask

// Back to back samples on both channels checked one edge later
task automatic run_stream(string name, int n, logic loop_on);
  raw_t      ra;
  raw_t      rb;
  sample_t   wa;
  sample_t   wb;
  sample_t   ca;
  sample_t   cb;
  sample_t   pa;
  sample_t   pb;
  dac_code_t da;
  dac_code_t db;
  for (int k = 0; k <= n; k++)
  begin
    ra = raw_t'($random(seed));
    rb = raw_t'($random(seed));
    rand_pair(wa, ca, (k % 4) == 0);
    rand_pair(wb, cb, (k % 4) == 2);
    @(posedge adc_clk);
    adc_a_raw_i    <= ra;
    adc_b_raw_i    <= rb;
    wave_a_i       <= wa;
    wave_b_i       <= wb;
    corr_a_i       <= ca;
    corr_b_i       <= cb;
    digital_loop_i <= loop_on;
    @(negedge adc_clk);
    if (k > 0)
    begin
      check_sample({name, " adc a"}, pa, adc_a_o);
      check_sample({name, " adc b"}, pb, adc_b_o);
      check_dac({name, " dac a"}, da, dac_a_o);
      check_dac({name, " dac b"}, db, dac_b_o);
    end
    // Expected for the samples just driven
    pa = loop_on ? sat_sum(wa, ca) : conv_raw(ra);
    pb = loop_on ? sat_sum(wb, cb) : conv_raw(rb);
    da = enc_dac(sat_sum(wa, ca));
    db = enc_dac(sat_sum(wb, cb));
  end
endtask

// CH A sample on the selected path and baseline on the other one
task automatic drive_a(sample_t s);
  if (digital_loop_i)
  begin
    adc_a_raw_i <= make_raw(BASE, 2'($random(seed)));
    wave_a_i    <= s;
  end
  else
  begin
    adc_a_raw_i <= make_raw(s, 2'($random(seed)));
    wave_a_i    <= BASE;
  end
  corr_a_i <= '0;
endtask

task automatic new_thresholds();
  for (int i = 0; i < NUM_THRESH; i++)
    thr[i] = sample_t'(rand_range(-2000, 6000));
  @(posedge adc_clk);
  thresh_i <= thr;
endtask

// Pulse of rise and held peak and one falling sample before baseline
task automatic run_pulse(string name);
  sample_t     lo;
  sample_t     hold;
  sample_t     s;
  photon_num_t peak;
  int          n_rise;
  int          n_hold;
  int          lat;
  logic        seen;
  lo     = thr_min(thr);
  hold   = rand_above(lo);
  n_rise = rand_range(1, 2);
  n_hold = rand_range(2, 5);
  peak   = '0;
  for (int i = 0; i <= n_rise + n_hold; i++)
  begin
    s = (i >= n_rise && i < n_rise + n_hold) ? hold : rand_above(lo);
    if (level_of(s, thr) > peak)
      peak = level_of(s, thr);  // running peak
    @(posedge adc_clk);
    drive_a(s);
  end
  @(posedge adc_clk);
  drive_a(BASE);  // first zero-level sample
  seen = 1'b0;
  lat  = 0;
  while (!seen && lat < EVT_TMO)
  begin
    @(posedge adc_clk);
    lat++;
    @(negedge adc_clk);
    seen = photon_vld_o;
  end
  if (!seen)
  begin
    $display("Timeout %s: no photon event arrived within %0d cycles", name, EVT_TMO);
    fail_stop();
  end
  check_latency(name, 3, lat);
  check_photon(name, peak, photon_num_o);
  tally[peak]++;
endtask

// Walk every select where 0 and 7 read zero
task automatic check_hist(string name);
  logic [HIST_W-1:0] exp;
  for (int sel = 0; sel < 8; sel++)
  begin
    exp = HIST_W'(tally[sel]);
    @(posedge adc_clk);
    hist_sel_i <= photon_num_t'(sel);
    @(negedge adc_clk);
    check_count($sformatf("%s sel %0d", name, sel), exp, hist_cnt_o);
  end
endtask

///////////////////////////////////////////////////////////////////////
// Test sequence
///////////////////////////////////////////////////////////////////////

initial
begin
  thr = {NUM_THRESH{MAX_S}};  // no level while streaming
  rst_n_i        <= 1'b0;
  adc_a_raw_i    <= make_raw(BASE, 2'b00);
  adc_b_raw_i    <= '0;
  digital_loop_i <= 1'b0;
  wave_a_i       <= '0;
  wave_b_i       <= '0;
  corr_a_i       <= '0;
  corr_b_i       <= '0;
  thresh_i       <= thr;
  hist_clr_i     <= 1'b0;
  hist_sel_i     <= '0;
  repeat (RST_CYC) @(posedge adc_clk);
  rst_n_i <= 1'b1;
  @(negedge adc_clk);
  check_dac("reset dac a", 14'h1FFF, dac_a_o);
  check_dac("reset dac b", 14'h1FFF, dac_b_o);
  check_flag("reset photon_vld_o", 1'b0, photon_vld_o);
  check_hist("reset histogram");

  run_stream("adc conversion", N_STREAM, 1'b0);
  run_stream("loopback", N_STREAM, 1'b1);

  // Loopback mode flips every 8 pulses
  for (int p = 0; p < N_PULSE; p++)
  begin
    if (p % 8 == 0)
    begin
      @(posedge adc_clk);
      digital_loop_i <= p[3];
      drive_a(BASE);
      new_thresholds();
    end
    run_pulse($sformatf("pulse %0d", p));
  end

  check_hist("histogram");
  @(posedge adc_clk);
  hist_clr_i <= 1'b1;
  @(posedge adc_clk);
  hist_clr_i <= 1'b0;
  tally = '{default: 0};
  check_hist("histogram clear");

  $display("PASS: all tests");
  $finish;
end

endmodule

/* pnr_top.f */
common/pnr_pkg.sv
hdl/adc_frontend.sv
hdl/dac_backend.sv
pnr/pnr_level.sv
pnr/pnr_pulse_fsm.sv
pnr/pnr_histogram.sv
hdl/pnr_top.sv
bench/pnr_top_assertions.sv
bench/pnr_top_tb.sv

/* Bender.yml */
package:
  name: pnr_top

sources:
  # Shared package first
  - files:
      - common/pnr_pkg.sv
  # RTL
  - files:
      - hdl/adc_frontend.sv
      - hdl/dac_backend.sv
      - pnr/pnr_level.sv
      - pnr/pnr_pulse_fsm.sv
      - pnr/pnr_histogram.sv
      - hdl/pnr_top.sv
  # Testbench
  - target: test
    files:
      - bench/pnr_top_assertions.sv
      - bench/pnr_top_tb.sv
